/* design/copy_engine.sv */
// Copy engine.
// Takes the next packet, unicast ahead of multicast, and walks its
// connection vector from the low index up, writing one copy per cycle.

`timescale 1ns/1ps

module copy_engine (
	input logic clk,
	input logic rst_n,
	input replicator_pkg::pkt_t ucast_pkt,
	input logic ucast_empty,
	input replicator_pkg::pkt_t mcast_pkt,
	input logic mcast_empty,
	input logic out_full,
	output logic ucast_rd,
	output logic mcast_rd,
	output logic out_wr,
	output replicator_pkg::copy_t out_copy
);

	import replicator_pkg::*;

	logic held_valid;
	conn_vec_t held_vec; // Remaining connections, shifted down.
	conn_t offset;
	count_t idx;
	count_t total;
	pri_t held_pri;
	desc_t held_desc;

	count_t pos;
	conn_t conn;
	logic last;
	logic release_pkt;
	logic load;
	pkt_t new_pkt;

	assign pos = pri_enc(held_vec);
	assign conn = conn_t'(count_t'(offset) + pos - count_t'(1));
	assign last = (idx == total - count_t'(1));

	assign out_wr = held_valid & ~out_full;
	assign release_pkt = out_wr & last;

	// Load while the final copy leaves so no cycle is lost between packets.
	assign ucast_rd = (~held_valid | release_pkt) & ~ucast_empty;
	assign mcast_rd = (~held_valid | release_pkt) & ucast_empty & ~mcast_empty;
	assign load = ucast_rd | mcast_rd;
	assign new_pkt = ucast_rd ? ucast_pkt : mcast_pkt;

	always_comb
	begin
		out_copy.ucast = (total == count_t'(1));
		out_copy.last = last;
		out_copy.packet_id = idx;
		out_copy.qid = {held_pri, conn};
		out_copy.desc = held_desc;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			held_pri <= new_pkt.pri;
			held_desc <= new_pkt.desc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			held_valid <= 1'b0;
			held_vec <= '0;
			offset <= '0;
			idx <= '0;
			total <= '0;
		end
		else if (load)
		begin
			held_valid <= 1'b1;
			held_vec <= new_pkt.vec;
			offset <= '0;
			idx <= '0;
			total <= new_pkt.count;
		end
		else if (release_pkt)
			held_valid <= 1'b0;
		else if (out_wr)
		begin
			held_vec <= held_vec >> pos; // Drop the bit just used.
			offset <= offset + conn_t'(pos);
			idx <= idx + count_t'(1);
		end
	end

endmodule

/* design/enq_classifier.sv */
// Enqueue classifier.
// Registers an enqueue request, counts its connections and sends it to the
// unicast FIFO, the multicast FIFO or the discard port.

`timescale 1ns/1ps

module enq_classifier (
	input logic clk,
	input logic rst_n,
	input logic enq_req,
	input logic enq_discard,
	input logic enq_allow_mcast,
	input replicator_pkg::conn_vec_t enq_vec,
	input replicator_pkg::pri_t enq_pri,
	input replicator_pkg::desc_t enq_desc,
	input logic ucast_full,
	input logic mcast_full,
	output logic ucast_wr,
	output logic mcast_wr,
	output replicator_pkg::pkt_t pkt,
	output logic discard_req,
	output replicator_pkg::desc_t discard_desc
);

	import replicator_pkg::*;

	logic req_d1;
	logic discard_d1;
	logic allow_mcast_d1;
	conn_vec_t vec_d1;
	pri_t pri_d1;
	desc_t desc_d1;

	count_t copy_cnt;
	logic is_ucast;
	logic is_mcast;
	logic discard_set;

	always_ff @(posedge clk)
	begin
		discard_d1 <= enq_discard;
		allow_mcast_d1 <= enq_allow_mcast;
		vec_d1 <= enq_vec;
		pri_d1 <= enq_pri;
		desc_d1 <= enq_desc;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			req_d1 <= 1'b0;
		else
			req_d1 <= enq_req;
	end

	assign copy_cnt = bits_sum(vec_d1);
	assign is_ucast = (copy_cnt == count_t'(1));
	assign is_mcast = (copy_cnt > count_t'(1));

	assign ucast_wr = req_d1 & ~discard_d1 & is_ucast & ~ucast_full;
	assign mcast_wr = req_d1 & ~discard_d1 & is_mcast & allow_mcast_d1 & ~mcast_full;
	assign discard_set = req_d1 & ~ucast_wr & ~mcast_wr; // Empty vector lands here too.

	always_comb
	begin
		pkt.vec = vec_d1;
		pkt.pri = pri_d1;
		pkt.count = copy_cnt;
		pkt.desc = desc_d1;
	end

	always_ff @(posedge clk)
	begin
		if (discard_set)
			discard_desc <= desc_d1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			discard_req <= 1'b0;
		else
			discard_req <= discard_set;
	end

endmodule

/* design/mcast_replicator.sv */
// Multicast replicator top level.
// Classifier, unicast and multicast input FIFOs, copy engine and the
// output FIFO that presents copies under back-pressure.

`timescale 1ns/1ps

module mcast_replicator #(
	parameter int FIFO_DEPTH_NBITS = 3
)(
	input logic clk,
	input logic rst_n,
	input logic enq_req,
	input logic enq_discard,
	input logic enq_allow_mcast,
	input replicator_pkg::conn_vec_t enq_vec,
	input replicator_pkg::pri_t enq_pri,
	input replicator_pkg::desc_t enq_desc,
	input logic rep_bp,
	output logic discard_req,
	output replicator_pkg::desc_t discard_desc,
	output logic rep_req,
	output replicator_pkg::copy_t rep_copy
);

	import replicator_pkg::*;

	localparam int OUT_DEPTH_NBITS = 1; // Two entries.

	pkt_t cls_pkt;
	logic ucast_wr, ucast_rd, ucast_full, ucast_empty;
	logic mcast_wr, mcast_rd, mcast_full, mcast_empty;
	pkt_t ucast_pkt;
	pkt_t mcast_pkt;
	logic out_wr, out_full, out_empty;
	copy_t out_copy;

	assign rep_req = ~out_empty & ~rep_bp;

	enq_classifier u_classifier (
		.clk(clk),
		.rst_n(rst_n),
		.enq_req(enq_req),
		.enq_discard(enq_discard),
		.enq_allow_mcast(enq_allow_mcast),
		.enq_vec(enq_vec),
		.enq_pri(enq_pri),
		.enq_desc(enq_desc),
		.ucast_full(ucast_full),
		.mcast_full(mcast_full),
		.ucast_wr(ucast_wr),
		.mcast_wr(mcast_wr),
		.pkt(cls_pkt),
		.discard_req(discard_req),
		.discard_desc(discard_desc)
	);

	sync_fifo #(.entry_t(pkt_t), .DEPTH_NBITS(FIFO_DEPTH_NBITS)) u_ucast_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr(ucast_wr),
		.din(cls_pkt),
		.rd(ucast_rd),
		.dout(ucast_pkt),
		.full(ucast_full),
		.empty(ucast_empty)
	);

	sync_fifo #(.entry_t(pkt_t), .DEPTH_NBITS(FIFO_DEPTH_NBITS)) u_mcast_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr(mcast_wr),
		.din(cls_pkt),
		.rd(mcast_rd),
		.dout(mcast_pkt),
		.full(mcast_full),
		.empty(mcast_empty)
	);

	copy_engine u_copy_engine (
		.clk(clk),
		.rst_n(rst_n),
		.ucast_pkt(ucast_pkt),
		.ucast_empty(ucast_empty),
		.mcast_pkt(mcast_pkt),
		.mcast_empty(mcast_empty),
		.out_full(out_full),
		.ucast_rd(ucast_rd),
		.mcast_rd(mcast_rd),
		.out_wr(out_wr),
		.out_copy(out_copy)
	);

	sync_fifo #(.entry_t(copy_t), .DEPTH_NBITS(OUT_DEPTH_NBITS)) u_out_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr(out_wr),
		.din(out_copy),
		.rd(rep_req),
		.dout(rep_copy),
		.full(out_full),
		.empty(out_empty)
	);

endmodule

/* design/replicator_pkg.sv */
// Replicator shared definitions.
// Field widths, packet and copy types, and the population count and
// lowest-bit encoder used by the classifier and the copy engine.

package replicator_pkg;

	localparam int CONN_NBITS = 3;
	localparam int VEC_NBITS = 2 ** CONN_NBITS;
	localparam int PRI_NBITS = 2;
	localparam int PTR_NBITS = 16;
	localparam int LEN_NBITS = 14;
	localparam int PORT_NBITS = 4;

	typedef logic [VEC_NBITS-1:0] conn_vec_t;
	typedef logic [CONN_NBITS-1:0] conn_t;
	typedef logic [PRI_NBITS-1:0] pri_t;
	typedef logic [PRI_NBITS+CONN_NBITS-1:0] qid_t; // {pri, conn}.
	typedef logic [CONN_NBITS:0] count_t;

	typedef struct packed {
		logic [PTR_NBITS-1:0] buf_ptr;
		logic [LEN_NBITS-1:0] len;
		logic [PORT_NBITS-1:0] src_port;
	} desc_t;

	typedef struct packed {
		conn_vec_t vec;
		pri_t pri;
		count_t count;
		desc_t desc;
	} pkt_t;

	typedef struct packed {
		logic ucast;
		logic last;
		count_t packet_id;
		qid_t qid;
		desc_t desc;
	} copy_t;

	function automatic count_t bits_sum(input conn_vec_t vec);
		count_t sum;
		sum = '0;
		for (int i = 0; i < VEC_NBITS; i++)
			sum = sum + count_t'(vec[i]);
		return sum;
	endfunction

	// One plus index of the lowest set bit, zero when empty.
	function automatic count_t pri_enc(input conn_vec_t vec);
		count_t pos;
		pos = '0;
		for (int i = VEC_NBITS - 1; i >= 0; i--)
			if (vec[i])
				pos = count_t'(i + 1);
		return pos;
	endfunction

endpackage

/* design/sync_fifo.sv */
// Synchronous FIFO.
// Register-array circular buffer with a typed entry. The head is read
// combinationally; writes when full and reads when empty are ignored.

`timescale 1ns/1ps

module sync_fifo #(
	parameter type entry_t = logic [7:0],
	parameter int DEPTH_NBITS = 3
)(
	input logic clk,
	input logic rst_n,
	input logic wr,
	input entry_t din,
	input logic rd,
	output entry_t dout,
	output logic full,
	output logic empty
);

	localparam int DEPTH = 2 ** DEPTH_NBITS;

	entry_t mem [DEPTH];
	logic [DEPTH_NBITS-1:0] wr_ptr;
	logic [DEPTH_NBITS-1:0] rd_ptr;
	logic [DEPTH_NBITS:0] count;

	logic do_wr;
	logic do_rd;

	assign full = (count == (DEPTH_NBITS + 1)'(DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr & ~full;
	assign do_rd = rd & ~empty;
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at depth.
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

/* mcast_replicator.f */
design/replicator_pkg.sv
design/sync_fifo.sv
design/enq_classifier.sv
design/copy_engine.sv
design/mcast_replicator.sv
verification/mcast_replicator_chk.sv
verification/tb_mcast_replicator.sv

/* verification/mcast_replicator_chk.sv */
// Output checks for the multicast replicator.
// Bound into the top level; watches back-pressure, reset and unicast copies.

`timescale 1ns/1ps

module mcast_replicator_chk (
	input logic clk,
	input logic rst_n,
	input logic rep_bp,
	input logic rep_req,
	input logic discard_req,
	input replicator_pkg::copy_t rep_copy
);

	int fail_count = 0; // Failed assertions so far.

	no_req_under_bp: assert property (@(posedge clk) disable iff (!rst_n) rep_bp |-> !rep_req)
	else
	begin
		$error("rep_req high while rep_bp is high");
		fail_count = fail_count + 1;
	end

	quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !discard_req && !rep_req)
	else
	begin
		$error("Output strobe high in the cycle after reset");
		fail_count = fail_count + 1;
	end

	// A unicast copy is its packet's only copy.
	ucast_single: assert property (@(posedge clk) disable iff (!rst_n)
		rep_req && rep_copy.ucast |-> rep_copy.last && rep_copy.packet_id == '0)
	else
	begin
		$error("Unicast copy without last or with nonzero packet_id");
		fail_count = fail_count + 1;
	end

endmodule

bind mcast_replicator mcast_replicator_chk u_chk (
	.clk(clk),
	.rst_n(rst_n),
	.rep_bp(rep_bp),
	.rep_req(rep_req),
	.discard_req(discard_req),
	.rep_copy(rep_copy)
);

/* verification/replicator_trace.txt */
// One 64-bit hex record per word. 1_flags_vec_pri_src_len_buf_00 is a packet (flags bit0 discard,
// bit1 allow_mcast). 2_0_00_00_0000_0000_hold holds back-pressure until hold cycles after the
// last packet. 3_flags_id_qid_0000_buf_00 is an expected copy (flags bit0 ucast, bit1 last).
// 4_0_00_00_len_buf_00 is an expected discard. F_0_00_00_0000_0000_00 ends a test.

// Unicast packets.
1_0_10_2_3_0040_1000_00
1_2_01_0_1_0080_1001_00
1_0_80_3_7_03ff_1002_00
3_3_00_14_0000_1000_00 3_3_00_00_0000_1001_00 3_3_00_1f_0000_1002_00
F_0_00_00_0000_0000_00

// Multicast packets.
1_2_0b_1_2_0100_2000_00
1_2_81_2_4_0020_2001_00
3_0_00_08_0000_2000_00 3_0_01_09_0000_2000_00 3_2_02_0b_0000_2000_00
3_0_00_10_0000_2001_00 3_2_01_17_0000_2001_00
F_0_00_00_0000_0000_00

// Discards.
1_1_04_0_0_0011_3000_00
1_2_00_1_0_0022_3001_00
1_0_0c_2_0_0033_3002_00
1_3_30_3_0_0044_3003_00
4_0_00_00_0011_3000_00 4_0_00_00_0022_3001_00
4_0_00_00_0033_3002_00 4_0_00_00_0044_3003_00
F_0_00_00_0000_0000_00

// Back-pressure fills the multicast FIFO.
2_0_00_00_0000_0000_0a
1_2_03_0_0_0010_4000_00
1_2_03_0_0_0010_4001_00
1_2_03_0_0_0010_4002_00
1_2_03_0_0_0010_4003_00
1_2_03_0_0_0010_4004_00
1_2_03_0_0_0010_4005_00
1_2_03_0_0_0010_4006_00
1_2_03_0_0_0010_4007_00
1_2_03_0_0_0010_4008_00
1_2_03_0_0_0010_4009_00
1_2_03_0_0_0010_400a_00
3_0_00_00_0000_4000_00 3_2_01_01_0000_4000_00
3_0_00_00_0000_4001_00 3_2_01_01_0000_4001_00
3_0_00_00_0000_4002_00 3_2_01_01_0000_4002_00
3_0_00_00_0000_4003_00 3_2_01_01_0000_4003_00
3_0_00_00_0000_4004_00 3_2_01_01_0000_4004_00
3_0_00_00_0000_4005_00 3_2_01_01_0000_4005_00
3_0_00_00_0000_4006_00 3_2_01_01_0000_4006_00
3_0_00_00_0000_4007_00 3_2_01_01_0000_4007_00
3_0_00_00_0000_4008_00 3_2_01_01_0000_4008_00
3_0_00_00_0000_4009_00 3_2_01_01_0000_4009_00
4_0_00_00_0010_400a_00
F_0_00_00_0000_0000_00

// Unicast behind queued multicast.
2_0_00_00_0000_0000_06
1_2_05_1_0_0030_5000_00
1_2_05_1_0_0030_5001_00
1_2_05_1_0_0030_5002_00
1_0_40_2_5_0030_5003_00
3_0_00_08_0000_5000_00 3_2_01_0a_0000_5000_00
3_0_00_08_0000_5001_00 3_2_01_0a_0000_5001_00
3_0_00_08_0000_5002_00 3_2_01_0a_0000_5002_00
3_3_00_16_0000_5003_00
F_0_00_00_0000_0000_00

/* verification/tb_mcast_replicator.sv */
// Testbench for the multicast replicator.
// Replays packets from the trace file and matches every copy and discard
// against the expected records of the same test.

`timescale 1ns/1ps

module tb_mcast_replicator;

	import replicator_pkg::*;

	localparam int TRACE_WORDS = 256;

	logic clk;
	logic rst_n;
	logic enq_req;
	logic enq_discard;
	logic enq_allow_mcast;
	conn_vec_t enq_vec;
	pri_t enq_pri;
	desc_t enq_desc;
	logic rep_bp;
	logic discard_req;
	desc_t discard_desc;
	logic rep_req;
	copy_t rep_copy;

	logic [63:0] trace_mem [TRACE_WORDS];
	logic [63:0] pkt_q [$];
	logic [63:0] ucast_exp [$]; // Unicast may overtake multicast.
	logic [63:0] mcast_exp [$];
	logic [63:0] disc_exp [$];
	logic [1:0] enq_hist; // enq_req at the last two negedges.
	int trace_len;
	int err_count;

	mcast_replicator dut (
		.clk(clk),
		.rst_n(rst_n),
		.enq_req(enq_req),
		.enq_discard(enq_discard),
		.enq_allow_mcast(enq_allow_mcast),
		.enq_vec(enq_vec),
		.enq_pri(enq_pri),
		.enq_desc(enq_desc),
		.rep_bp(rep_bp),
		.discard_req(discard_req),
		.discard_desc(discard_desc),
		.rep_req(rep_req),
		.rep_copy(rep_copy)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		wait (trace_len > 0);
		repeat (trace_len * 40) @(posedge clk);
		$display("Timeout: expected outputs still missing after %0d cycles", trace_len * 40);
		$display("TESTS FAILED");
		$finish;
	end

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic match_copy(input copy_t got);
		logic [63:0] exp;
		logic from_ucast;
		from_ucast = (ucast_exp.size() > 0) && (ucast_exp[0][23:8] == got.desc.buf_ptr);
		if (!from_ucast && mcast_exp.size() == 0)
		begin
			$display("Copy for buf_ptr %h arrived at %0t ns with none expected",
				got.desc.buf_ptr, $time);
			err_count++;
		end
		else
		begin
			if (from_ucast)
				exp = ucast_exp.pop_front();
			else
				exp = mcast_exp.pop_front();
			compare("copy ucast", got.ucast, exp[56]);
			compare("copy last", got.last, exp[57]);
			compare("copy packet_id", got.packet_id, exp[55:48]);
			compare("copy qid", got.qid, exp[47:40]);
			compare("copy buf_ptr", got.desc.buf_ptr, exp[23:8]);
		end
	endtask

	task automatic match_discard(input desc_t got);
		logic [63:0] exp;
		if (disc_exp.size() == 0)
		begin
			$display("Discard of buf_ptr %h at %0t ns was not expected", got.buf_ptr, $time);
			err_count++;
		end
		else
		begin
			exp = disc_exp.pop_front();
			compare("discard buf_ptr", got.buf_ptr, exp[23:8]);
			compare("discard len", got.len, exp[37:24]);
		end
	endtask

	task automatic send_packet(input logic [63:0] rec);
		int gap;
		@(posedge clk);
		enq_req <= 1'b1;
		enq_discard <= rec[56];
		enq_allow_mcast <= rec[57];
		enq_vec <= rec[55:48];
		enq_pri <= rec[45:44];
		enq_desc <= {rec[23:8], rec[37:24], rec[43:40]}; // buf_ptr, len, src_port.
		@(posedge clk);
		enq_req <= 1'b0;
		gap = $urandom % 4;
		repeat (gap) @(posedge clk);
	endtask

	// Sampled mid-cycle, where outputs are settled.
	always @(negedge clk)
	begin
		if (rst_n && rep_req)
			match_copy(rep_copy);
		if (rst_n && discard_req)
		begin
			compare("enq_req two cycles before discard", enq_hist[1], 1'b1);
			match_discard(discard_desc);
		end
		enq_hist = {enq_hist[0], enq_req};
	end

	initial
	begin
		int idx;
		int len;
		int hold;
		int tests;
		int failed;
		int errs_before;
		logic [63:0] rec;
		void'($urandom(32'hdd58));
		rst_n = 1'b0;
		enq_req = 1'b0;
		enq_discard = 1'b0;
		enq_allow_mcast = 1'b0;
		enq_vec = '0;
		enq_pri = '0;
		enq_desc = '0;
		rep_bp = 1'b0;
		enq_hist = '0;
		err_count = 0;
		tests = 0;
		failed = 0;
		foreach (trace_mem[i])
			trace_mem[i] = '0;
		$readmemh("verification/replicator_trace.txt", trace_mem);
		len = 0;
		while (len < TRACE_WORDS && trace_mem[len][63:60] != 4'h0)
			len++;
		trace_len = len;
		if (len == 0)
		begin
			$display("No records were read from the trace file");
			err_count++;
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		idx = 0;
		while (idx < len)
		begin
			hold = -1; // No back-pressure window.
			while (idx < len && trace_mem[idx][63:60] != 4'hf)
			begin
				rec = trace_mem[idx];
				case (rec[63:60])
					4'h1: pkt_q.push_back(rec);
					4'h2: hold = int'(rec[7:0]);
					4'h3:
						if (rec[56])
							ucast_exp.push_back(rec);
						else
							mcast_exp.push_back(rec);
					4'h4: disc_exp.push_back(rec);
					default:
					begin
						$display("Unknown trace record %h", rec);
						err_count++;
					end
				endcase
				idx++;
			end
			idx++; // Skip the end-of-test record.
			tests++;
			errs_before = err_count;
			if (hold >= 0)
			begin
				@(posedge clk);
				rep_bp <= 1'b1;
			end
			while (pkt_q.size() > 0)
				send_packet(pkt_q.pop_front());
			if (hold >= 0)
			begin
				repeat (hold) @(posedge clk);
				rep_bp <= 1'b0;
			end
			while (ucast_exp.size() + mcast_exp.size() + disc_exp.size() > 0)
				@(posedge clk);
			repeat (4) @(posedge clk); // Stray outputs land in this test.
			if (err_count == errs_before)
				$display("Test %0d passed", tests);
			else
			begin
				failed++;
				$display("Test %0d failed with %0d errors", tests, err_count - errs_before);
			end
		end

		err_count = err_count + dut.u_chk.fail_count;
		$display("%0d tests run, %0d failed, %0d errors", tests, failed, err_count);
		if (err_count == 0 && tests > 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
